// File: logic/game_consts.svh
// Bank geometry, client count and ROM placement inside the shared SDRAM bank
// Included by the package and by every module that sizes bank-side signals
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Bank word address and read data widths
`define BANK_AW 22
`define BANK_DW 32

// Clients sharing the read-only bank
`define N_CLIENTS 3

// Base word address of each client ROM
`define MAIN_OFFSET 22'h000000
`define CHAR_OFFSET 22'h080000
`define SND_OFFSET  22'h100000

`endif

// File: logic/game_pkg.sv
// Types shared by the ROM slots, the bank arbiter and the top level
`default_nettype none

`include "game_consts.svh"

package game_pkg;

    // Word address on the SDRAM bank
    typedef logic [`BANK_AW-1:0] bank_addr_t;

    // Client index, lower value wins arbitration
    typedef enum logic [1:0] {
        CL_MAIN = 2'd0,
        CL_CHAR = 2'd1,
        CL_SND  = 2'd2
    } client_t;

endpackage

`default_nettype wire

// File: logic/bank_req_if.sv
// Read request channel between one ROM slot and the bank arbiter
// req/addr held until ack, data valid with a one-cycle rdy
`default_nettype none

`include "game_consts.svh"

interface bank_req_if;

    logic                   req;
    game_pkg::bank_addr_t   addr;
    logic                   ack;
    logic                   rdy;
    logic [`BANK_DW-1:0]    data;

    modport slot (
        output req,
        output addr,
        input  ack,
        input  rdy,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output ack,
        output rdy,
        output data
    );

endinterface

`default_nettype wire

// File: logic/rom_slot.sv
// Per-client ROM slot with a one-word cache in front of the bank arbiter
// Client holds cs/addr until ok; a repeated address is served without a bank read
`default_nettype none

module rom_slot #(
    parameter type                  data_t = logic [15:0],
    parameter game_pkg::bank_addr_t OFFSET = '0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cs,
    input  logic [19:0] addr,
    output logic        ok,
    output data_t       data,
    bank_req_if.slot    bus
);

    logic [19:0] last_addr;
    logic [19:0] pend_addr;
    logic        valid;
    logic        req;
    logic        wait_rdy;
    logic        hit;
    logic        miss;
    logic        fill;

    assign hit  = valid && addr == last_addr;
    assign miss = cs && !hit && !req && !wait_rdy;
    // rdy may come together with ack
    assign fill = bus.rdy && (wait_rdy || (req && bus.ack));

    assign bus.req  = req;
    assign bus.addr = game_pkg::bank_addr_t'(pend_addr) + OFFSET;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req      <= 1'b0;
            wait_rdy <= 1'b0;
            valid    <= 1'b0;
            ok       <= 1'b0;
        end else begin
            if (req) begin
                if (bus.ack) begin
                    req      <= 1'b0;
                    wait_rdy <= !bus.rdy;
                end
            end else if (wait_rdy) begin
                if (bus.rdy) begin
                    wait_rdy <= 1'b0;
                end
            end else if (miss) begin
                req <= 1'b1;
            end
            if (fill) begin
                valid <= 1'b1;
                // Fresh word, ok only if the client still wants it
                ok    <= cs && addr == pend_addr;
            end else begin
                ok    <= cs && hit;
            end
        end
    end

    // Cached word and address
    always_ff @(posedge clk) begin
        if (miss) begin
            pend_addr <= addr;
        end
        if (fill) begin
            last_addr <= pend_addr;
            data      <= data_t'(bus.data[$bits(data_t)-1:0]);
        end
    end

endmodule

`default_nettype wire

// File: logic/bank_arbiter.sv
// Fixed-priority arbiter putting slot reads one at a time on the SDRAM bank
// Lowest client index wins; ack and rdy go back only to the latched client
`default_nettype none

`include "game_consts.svh"

module bank_arbiter (
    input  logic                 clk,
    input  logic                 arst_n,
    bank_req_if.arbiter          slot [`N_CLIENTS],
    output game_pkg::bank_addr_t ba_addr,
    output logic                 ba_rd,
    input  logic                 ba_ack,
    input  logic                 ba_rdy,
    input  logic [`BANK_DW-1:0]  data_read
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RDY
    } state_t;

    state_t                 state;
    game_pkg::client_t      sel;
    game_pkg::client_t      winner;
    logic [`N_CLIENTS-1:0]  req_vec;
    game_pkg::bank_addr_t   addr_vec [`N_CLIENTS];
    logic                   rdy_r;
    logic [`BANK_DW-1:0]    data_r;

    // Interface arrays need constant indices
    for (genvar i = 0; i < `N_CLIENTS; i++) begin : g_slot
        assign req_vec[i]    = slot[i].req;
        assign addr_vec[i]   = slot[i].addr;
        assign slot[i].ack   = state == WAIT_ACK && ba_ack
                               && sel == game_pkg::client_t'(i);
        assign slot[i].rdy   = rdy_r && sel == game_pkg::client_t'(i);
        // Shared data, rdy picks the owner
        assign slot[i].data  = data_r;
    end

    always_comb begin
        winner = game_pkg::CL_MAIN;
        for (int i = `N_CLIENTS - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                winner = game_pkg::client_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            sel   <= game_pkg::CL_MAIN;
            ba_rd <= 1'b0;
            rdy_r <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (|req_vec) begin
                        state <= WAIT_ACK;
                        sel   <= winner;
                        ba_rd <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    if (ba_ack) begin
                        state <= WAIT_RDY;
                        ba_rd <= 1'b0;
                    end
                end
                WAIT_RDY: begin
                    // One cycle with rdy to the slot, then back to idle
                    if (rdy_r) begin
                        rdy_r <= 1'b0;
                        state <= IDLE;
                    end else if (ba_rdy) begin
                        rdy_r <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Bank address tracks the winner until the read starts
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            ba_addr <= addr_vec[winner];
        end
        if (state == WAIT_RDY && ba_rdy && !rdy_r) begin
            data_r <= data_read;
        end
    end

endmodule

`default_nettype wire

// File: logic/game_sdram.sv
// Read-only SDRAM bank sharing for the main CPU, char tile and sound CPU ROMs
// Each client gets a cached ROM slot; the arbiter drives the bank port
`default_nettype none

`include "game_consts.svh"

module game_sdram (
    input  logic                 clk,
    input  logic                 arst_n,

    // Main CPU program ROM
    input  logic                 main_cs,
    input  logic [19:0]          main_addr,
    output logic                 main_ok,
    output logic [15:0]          main_data,

    // Char tile ROM
    input  logic                 char_cs,
    input  logic [19:0]          char_addr,
    output logic                 char_ok,
    output logic [31:0]          char_data,

    // Sound CPU ROM
    input  logic                 snd_cs,
    input  logic [19:0]          snd_addr,
    output logic                 snd_ok,
    output logic [7:0]           snd_data,

    // SDRAM bank, read only
    output game_pkg::bank_addr_t ba_addr,
    output logic                 ba_rd,
    input  logic                 ba_ack,
    input  logic                 ba_rdy,
    input  logic [`BANK_DW-1:0]  data_read
);

    // One request channel per client, indexed by client_t
    bank_req_if bus [`N_CLIENTS] ();

    rom_slot #(
        .data_t ( logic [15:0]   ),
        .OFFSET ( `MAIN_OFFSET   )
    ) u_main (
        .clk    ( clk            ),
        .arst_n ( arst_n         ),
        .cs     ( main_cs        ),
        .addr   ( main_addr      ),
        .ok     ( main_ok        ),
        .data   ( main_data      ),
        .bus    ( bus[game_pkg::CL_MAIN] )
    );

    rom_slot #(
        .data_t ( logic [31:0]   ),
        .OFFSET ( `CHAR_OFFSET   )
    ) u_char (
        .clk    ( clk            ),
        .arst_n ( arst_n         ),
        .cs     ( char_cs        ),
        .addr   ( char_addr      ),
        .ok     ( char_ok        ),
        .data   ( char_data      ),
        .bus    ( bus[game_pkg::CL_CHAR] )
    );

    rom_slot #(
        .data_t ( logic [7:0]    ),
        .OFFSET ( `SND_OFFSET    )
    ) u_snd (
        .clk    ( clk            ),
        .arst_n ( arst_n         ),
        .cs     ( snd_cs         ),
        .addr   ( snd_addr       ),
        .ok     ( snd_ok         ),
        .data   ( snd_data       ),
        .bus    ( bus[game_pkg::CL_SND] )
    );

    bank_arbiter u_arb (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slot      ( bus       ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

endmodule

`default_nettype wire

// File: tb/sdram_bank_model.sv
// SDRAM bank stand-in for the testbench, answering ba_rd after random ack and rdy delays
// Read data follows the address rule; stall_max forces the longest delays
`default_nettype none

`include "game_consts.svh"

module sdram_bank_model (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall_max,
    input  logic [`BANK_AW-1:0] ba_addr,
    input  logic                ba_rd,
    output logic                ba_ack,
    output logic                ba_rdy,
    output logic [`BANK_DW-1:0] data_read
);

    typedef enum logic [1:0] {
        IDLE,
        ACK_WAIT,
        RDY_WAIT
    } state_t;

    state_t              state;
    logic [2:0]          count;
    logic [31:0]         rng;
    logic [`BANK_AW-1:0] addr_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Delay of 1 to 4 cycles
    function automatic logic [2:0] pick_delay(input logic [31:0] r, input logic slow);
        if (slow) begin
            return 3'd4;
        end
        return {1'b0, r[1:0]} + 3'd1;
    endfunction

    // Upper half is the low address bits, lower half their inverse
    function automatic logic [31:0] bank_word(input logic [`BANK_AW-1:0] a);
        return {a[15:0], ~a[15:0]};
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            count     <= 3'd0;
            rng       <= 32'h4463_3099;
            addr_q    <= '0;
            ba_ack    <= 1'b0;
            ba_rdy    <= 1'b0;
            data_read <= '0;
        end else begin
            ba_ack <= 1'b0;
            ba_rdy <= 1'b0;
            case (state)
                IDLE: begin
                    if (ba_rd) begin
                        addr_q <= ba_addr;
                        count  <= pick_delay(rng, stall_max);
                        rng    <= xorshift32(rng);
                        state  <= ACK_WAIT;
                    end
                end
                ACK_WAIT: begin
                    if (count == 3'd1) begin
                        ba_ack <= 1'b1;
                        count  <= pick_delay(rng, stall_max);
                        rng    <= xorshift32(rng);
                        state  <= RDY_WAIT;
                    end else begin
                        count <= count - 3'd1;
                    end
                end
                RDY_WAIT: begin
                    if (count == 3'd1) begin
                        ba_rdy    <= 1'b1;
                        data_read <= bank_word(addr_q);
                        state     <= IDLE;
                    end else begin
                        count <= count - 3'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb/game_sdram_tb.sv
// Testbench for game_sdram, applying a table of client requests to the three ROM slots
// Checks returned data, ok release and the order of bank reads against the address rule
`default_nettype none

`include "game_consts.svh"

module game_sdram_tb;

    localparam int N_ENTRIES    = 12;
    localparam int RESET_CYCLES = 5;
    // Three reads at the longest stalls plus drive and release cycles
    localparam int ENTRY_BUDGET = 3 * 16 + 16;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 10 + N_ENTRIES * ENTRY_BUDGET;
    localparam logic [`BANK_AW-1:0] OFFSETS [3] = '{`MAIN_OFFSET, `CHAR_OFFSET, `SND_OFFSET};

    typedef struct packed {
        logic [2:0]  mask;
        logic [2:0]  miss;
        logic        slow;
        logic [19:0] main_addr;
        logic [19:0] char_addr;
        logic [19:0] snd_addr;
    } entry_t;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                main_cs;
    logic [19:0]         main_addr;
    logic                main_ok;
    logic [15:0]         main_data;
    logic                char_cs;
    logic [19:0]         char_addr;
    logic                char_ok;
    logic [31:0]         char_data;
    logic                snd_cs;
    logic [19:0]         snd_addr;
    logic                snd_ok;
    logic [7:0]          snd_data;
    logic [`BANK_AW-1:0] ba_addr;
    logic                ba_rd;
    logic                ba_ack;
    logic                ba_rdy;
    logic [`BANK_DW-1:0] data_read;
    logic                stall_max;

    entry_t              entries [N_ENTRIES];
    logic [2:0]          ok_vec;
    logic [31:0]         got_data [3];
    logic [`BANK_AW-1:0] reads [$];
    logic                ba_rd_q;
    int                  rdy_count;
    int                  cycle_count;
    int                  errors = 0;

    always #5 clk = ~clk;

    game_sdram dut0 (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .main_cs   ( main_cs   ),
        .main_addr ( main_addr ),
        .main_ok   ( main_ok   ),
        .main_data ( main_data ),
        .char_cs   ( char_cs   ),
        .char_addr ( char_addr ),
        .char_ok   ( char_ok   ),
        .char_data ( char_data ),
        .snd_cs    ( snd_cs    ),
        .snd_addr  ( snd_addr  ),
        .snd_ok    ( snd_ok    ),
        .snd_data  ( snd_data  ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    sdram_bank_model bank0 (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .stall_max ( stall_max ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    assign ok_vec      = {snd_ok, char_ok, main_ok};
    assign got_data[0] = {16'h0000, main_data};
    assign got_data[1] = char_data;
    assign got_data[2] = {24'h000000, snd_data};

    // Log of every bank read, one entry per ba_rd rising edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ba_rd_q   <= 1'b0;
            rdy_count <= 0;
        end else begin
            ba_rd_q <= ba_rd;
            if (ba_rd && !ba_rd_q) begin
                reads.push_back(ba_addr);
            end
            if (ba_rdy) begin
                rdy_count <= rdy_count + 1;
            end
        end
    end

    function automatic logic [`BANK_AW-1:0] bank_address(input int i, input logic [19:0] a);
        return OFFSETS[i] + {{(`BANK_AW - 20){1'b0}}, a};
    endfunction

    // Bank rule cut down to the client payload width
    function automatic logic [31:0] expected_data(input int i, input logic [19:0] a);
        logic [`BANK_AW-1:0] ba;
        logic [31:0]         w;
        ba = bank_address(i, a);
        w  = {ba[15:0], ~ba[15:0]};
        case (i)
            0:       return {16'h0000, w[15:0]};
            1:       return w;
            default: return {24'h000000, w[7:0]};
        endcase
    endfunction

    task automatic check_cond(input logic cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic run_entry(input int n);
        entry_t              e;
        logic [19:0]         a [3];
        logic [2:0]          done;
        logic [`BANK_AW-1:0] got_addr;
        int                  read_base;
        int                  rdy_base;
        int                  rank;
        int                  k;
        e         = entries[n];
        a[0]      = e.main_addr;
        a[1]      = e.char_addr;
        a[2]      = e.snd_addr;
        done      = 3'b000;
        read_base = reads.size();
        rdy_base  = rdy_count;
        @(posedge clk);
        stall_max <= e.slow;
        main_cs   <= e.mask[0];
        char_cs   <= e.mask[1];
        snd_cs    <= e.mask[2];
        main_addr <= e.mask[0] ? a[0] : main_addr;
        char_addr <= e.mask[1] ? a[1] : char_addr;
        snd_addr  <= e.mask[2] ? a[2] : snd_addr;
        while ((done & e.mask) != e.mask) begin
            @(negedge clk);
            rank = 0;
            for (int i = 0; i < 3; i++) begin
                if (e.mask[i] && !done[i] && ok_vec[i]) begin
                    check_cond(got_data[i] == expected_data(i, a[i]),
                        $sformatf("entry %0d client %0d data %h, expected %h",
                                  n, i, got_data[i], expected_data(i, a[i])));
                    // A miss may only finish after its own bank data came back
                    if (e.miss[i]) begin
                        check_cond(rdy_count - rdy_base >= rank + 1,
                            $sformatf("entry %0d client %0d ok before bank data", n, i));
                    end
                    done[i] = 1'b1;
                end
                if (e.miss[i]) begin
                    rank++;
                end
            end
        end
        @(posedge clk);
        main_cs <= 1'b0;
        char_cs <= 1'b0;
        snd_cs  <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_cond(ok_vec == 3'b000, $sformatf("entry %0d ok %b after cs fell", n, ok_vec));
        // Missing clients reach the bank in priority order
        k = read_base;
        for (int i = 0; i < 3; i++) begin
            if (e.miss[i]) begin
                got_addr = (k < reads.size()) ? reads[k] : '1;
                check_cond(got_addr == bank_address(i, a[i]),
                    $sformatf("entry %0d bank read %0d at %h, expected %h",
                              n, k - read_base, got_addr, bank_address(i, a[i])));
                k++;
            end
        end
        check_cond(reads.size() == k,
            $sformatf("entry %0d issued %0d bank reads, expected %0d",
                      n, reads.size() - read_base, k - read_base));
    endtask

    initial begin
        arst_n    <= 1'b0;
        main_cs   <= 1'b0;
        main_addr <= 20'h00000;
        char_cs   <= 1'b0;
        char_addr <= 20'h00000;
        snd_cs    <= 1'b0;
        snd_addr  <= 20'h00000;
        stall_max <= 1'b0;
        // mask  miss  slow  main_addr  char_addr  snd_addr
        entries[0]  = '{3'b001, 3'b001, 1'b0, 20'h01234, 20'h00000, 20'h00000};
        entries[1]  = '{3'b010, 3'b010, 1'b0, 20'h00000, 20'h00abc, 20'h00000};
        entries[2]  = '{3'b100, 3'b100, 1'b0, 20'h00000, 20'h00000, 20'h0f0f1};
        entries[3]  = '{3'b001, 3'b000, 1'b0, 20'h01234, 20'h00000, 20'h00000};
        entries[4]  = '{3'b010, 3'b000, 1'b0, 20'h00000, 20'h00abc, 20'h00000};
        entries[5]  = '{3'b100, 3'b000, 1'b0, 20'h00000, 20'h00000, 20'h0f0f1};
        entries[6]  = '{3'b111, 3'b111, 1'b0, 20'h02000, 20'h03000, 20'h04000};
        entries[7]  = '{3'b001, 3'b001, 1'b0, 20'h02001, 20'h00000, 20'h00000};
        entries[8]  = '{3'b111, 3'b110, 1'b1, 20'h02001, 20'hfffff, 20'h5a5a5};
        entries[9]  = '{3'b111, 3'b111, 1'b1, 20'h0abcd, 20'h01111, 20'h02222};
        entries[10] = '{3'b101, 3'b000, 1'b0, 20'h0abcd, 20'h00000, 20'h02222};
        entries[11] = '{3'b111, 3'b111, 1'b0, 20'h0beef, 20'h00777, 20'h0c3c3};
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_cond({ba_rd, ok_vec} == 4'b0000, "bank read or ok active right after reset");
        for (int n = 0; n < N_ENTRIES; n++) begin
            run_entry(n);
        end
        $display("Errors: %0d, bank reads: %0d", errors, reads.size());
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit from the table length
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the run did not finish within %0d cycles (errors so far %0d)",
                 CYCLE_LIMIT, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: game_sdram.f
+incdir+logic
logic/game_pkg.sv
logic/bank_req_if.sv
logic/rom_slot.sv
logic/bank_arbiter.sv
logic/game_sdram.sv
tb/sdram_bank_model.sv
tb/game_sdram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the game_sdram testbench with Verilator, then scan the log for failure
verilator --binary --timing --assert -f game_sdram.f --top-module game_sdram_tb \
    -o game_sdram_sim \
    && ./obj_dir/game_sdram_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
